//--- src/alu_consts.svh
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// datapath and field widths of the execute path
`define ALU_WORD_W   32
`define ALU_REG_W    5
`define ALU_SHAMT_W  5
`define ALU_IMM_W    16
`define ALU_FIELD_W  6
`define ALU_OP_W     4

// cycles from the sampled in_valid to out_valid, one per registered stage
`define ALU_LATENCY  3

// primary opcodes, instr bits 0 to 5
`define OPC_RTYPE    6'h00
`define OPC_ADDI     6'h08
`define OPC_SUBI     6'h0A
`define OPC_ANDI     6'h0C
`define OPC_ORI      6'h0D
`define OPC_XORI     6'h0E
`define OPC_SLLI     6'h14
`define OPC_SRLI     6'h16
`define OPC_SRAI     6'h17
`define OPC_SEQI     6'h18
`define OPC_SLTI     6'h1A

// function codes for R-type, instr bits 26 to 31
`define FUNC_SLL     6'h04
`define FUNC_SRL     6'h06
`define FUNC_SRA     6'h07
`define FUNC_ADD     6'h20
`define FUNC_SUB     6'h22
`define FUNC_AND     6'h24
`define FUNC_OR      6'h25
`define FUNC_XOR     6'h26
`define FUNC_SEQ     6'h28
`define FUNC_SLT     6'h2A

`endif

//--- src/alu_pkg.sv
`include "alu_consts.svh"

package alu_pkg;

    // all vectors count from 0 at the most significant bit
    typedef logic [0:`ALU_WORD_W-1]  word_t;
    typedef logic [0:`ALU_REG_W-1]   reg_idx_t;
    // bit 0 of a shift amount selects the 16-place stage
    typedef logic [0:`ALU_SHAMT_W-1] shamt_t;
    typedef logic [0:`ALU_IMM_W-1]   imm_t;
    // opcode and function fields share one width
    typedef logic [0:`ALU_FIELD_W-1] opfield_t;

    // operation after decode, I-type forms fold onto their R-type twin
    typedef enum logic [`ALU_OP_W-1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SEQ,
        ALU_SLT
    } alu_op_e;

    // one instruction with both register operands already fetched
    typedef struct packed {
        word_t instr;
        word_t a;
        word_t b;
    } alu_req_t;

    // item between decode and execute
    typedef struct packed {
        alu_op_e  op;
        word_t    opa;
        word_t    opb;
        shamt_t   shamt;
        reg_idx_t rd;
        logic     illegal;
    } dec_t;

    // item between execute and result
    typedef struct packed {
        word_t    value;
        logic     overflow;
        reg_idx_t rd;
        logic     illegal;
    } exe_t;

    // response seen by the write-back side
    typedef struct packed {
        word_t    value;
        reg_idx_t rd;
        logic     wb_en;
        logic     zero;
        logic     negative;
        logic     overflow;
        logic     illegal;
    } alu_rsp_t;

endpackage

//--- src/barrel_shift.sv
`timescale 1ns/100ps
`include "alu_consts.svh"

module barrel_shift import alu_pkg::*; (
    input  word_t  x,
    input  shamt_t shamt,
    input  logic   arith,
    input  logic   right,
    output word_t  z
);

    localparam int W = `ALU_WORD_W;

    // stage 0 of each chain is the unshifted input, stage 5 is the final result
    word_t lstage [0:5];
    word_t rstage [0:5];
    // bit shifted in from the top on a right shift
    logic  fill;

    // only a right arithmetic shift of a negative word fills with ones
    assign fill = arith & x[0];

    assign lstage[0] = x;
    assign rstage[0] = x;

    // each stage handles one shamt bit, going from 16 places down to 1 place
    // and shamt[s] is the bit of weight 16 >> s
    for (genvar s = 0; s < 5; s++) begin : g_stage
        // number of places this stage moves the word
        localparam int N = 16 >> s;

        // left shift pushes bits toward index 0 and zero fills the bottom
        assign lstage[s+1] = shamt[s] ? {lstage[s][N:W-1], {N{1'b0}}}
                                      : lstage[s];

        // right shift pushes bits toward index W-1 and puts fill on top
        assign rstage[s+1] = shamt[s] ? {{N{fill}}, rstage[s][0:W-1-N]}
                                      : rstage[s];
    end

    // both chains run in parallel, the direction bit just picks one at the end
    assign z = right ? rstage[5] : lstage[5];

endmodule

//--- src/op_decode.sv
`timescale 1ns/100ps
`include "alu_consts.svh"

module op_decode import alu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  alu_req_t req,
    input  logic     in_valid,
    output dec_t     dec,
    output logic     dec_valid
);

    localparam int W = `ALU_WORD_W;

    opfield_t opcode;
    opfield_t func;
    imm_t     imm;
    logic     is_rtype;
    logic     imm_signed;
    word_t    imm_ext;
    dec_t     dec_c;

    // instruction fields, counted from the MSB like the rest of the datapath
    assign opcode   = req.instr[0:5];
    assign func     = req.instr[26:31];
    assign imm      = req.instr[16:31];
    assign is_rtype = (opcode == `OPC_RTYPE);

    // arithmetic and compare immediates are signed, logic immediates are not
    assign imm_signed = opcode inside {`OPC_ADDI, `OPC_SUBI, `OPC_SEQI, `OPC_SLTI};
    assign imm_ext    = imm_signed ? {{(W-16){imm[0]}}, imm} : {{(W-16){1'b0}}, imm};

    always_comb begin
        dec_c.op      = ALU_ADD;
        dec_c.illegal = 1'b0;
        if (is_rtype) begin
            case (func)
                `FUNC_ADD: dec_c.op = ALU_ADD;
                `FUNC_SUB: dec_c.op = ALU_SUB;
                `FUNC_AND: dec_c.op = ALU_AND;
                `FUNC_OR:  dec_c.op = ALU_OR;
                `FUNC_XOR: dec_c.op = ALU_XOR;
                `FUNC_SLL: dec_c.op = ALU_SLL;
                `FUNC_SRL: dec_c.op = ALU_SRL;
                `FUNC_SRA: dec_c.op = ALU_SRA;
                `FUNC_SEQ: dec_c.op = ALU_SEQ;
                `FUNC_SLT: dec_c.op = ALU_SLT;
                default:   dec_c.illegal = 1'b1;
            endcase
        end else begin
            case (opcode)
                `OPC_ADDI: dec_c.op = ALU_ADD;
                `OPC_SUBI: dec_c.op = ALU_SUB;
                `OPC_ANDI: dec_c.op = ALU_AND;
                `OPC_ORI:  dec_c.op = ALU_OR;
                `OPC_XORI: dec_c.op = ALU_XOR;
                `OPC_SLLI: dec_c.op = ALU_SLL;
                `OPC_SRLI: dec_c.op = ALU_SRL;
                `OPC_SRAI: dec_c.op = ALU_SRA;
                `OPC_SEQI: dec_c.op = ALU_SEQ;
                `OPC_SLTI: dec_c.op = ALU_SLT;
                default:   dec_c.illegal = 1'b1;
            endcase
        end
        dec_c.opa = req.a;
        // the immediate replaces b for every I-type form
        dec_c.opb = is_rtype ? req.b : imm_ext;
        // shift amount is the low five bits of whichever second operand applies
        dec_c.shamt = is_rtype ? req.b[W-5:W-1] : imm[11:15];
        // rd sits in different places for R-type and I-type
        dec_c.rd = is_rtype ? req.instr[16:20] : req.instr[11:15];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    // the decoded item only moves on a strobe
    always_ff @(posedge clk) begin
        if (in_valid) begin
            dec <= dec_c;
        end
    end

endmodule

//--- src/alu_execute.sv
`timescale 1ns/100ps

module alu_execute import alu_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  dec_t dec,
    input  logic dec_valid,
    output exe_t exe,
    output logic exe_valid
);

    word_t b_in;
    word_t sum;
    word_t shifted;
    word_t value_c;
    logic  sub_mode;
    logic  add_ovf;
    logic  less;
    logic  equal;
    logic  shift_arith;
    logic  shift_right;
    exe_t  exe_c;

    // sub and both compares share the adder in subtract mode
    assign sub_mode = dec.op inside {ALU_SUB, ALU_SEQ, ALU_SLT};

    // subtraction is a plus the inverted b plus one on the carry in
    assign b_in = sub_mode ? ~dec.opb : dec.opb;
    assign sum  = dec.opa + b_in + word_t'(sub_mode);

    // signed overflow when both adder inputs agree in sign and the sum does not
    assign add_ovf = (dec.opa[0] == b_in[0]) && (sum[0] != dec.opa[0]);

    // a minus b is negative, corrected by overflow, exactly when a < b signed
    assign less  = sum[0] ^ add_ovf;
    assign equal = (dec.opa == dec.opb);

    assign shift_arith = (dec.op == ALU_SRA);
    assign shift_right = dec.op inside {ALU_SRL, ALU_SRA};

    barrel_shift u_shift (
        .x     (dec.opa),
        .shamt (dec.shamt),
        .arith (shift_arith),
        .right (shift_right),
        .z     (shifted)
    );

    always_comb begin
        case (dec.op)
            ALU_ADD, ALU_SUB:         value_c = sum;
            ALU_AND:                  value_c = dec.opa & dec.opb;
            ALU_OR:                   value_c = dec.opa | dec.opb;
            ALU_XOR:                  value_c = dec.opa ^ dec.opb;
            ALU_SLL, ALU_SRL, ALU_SRA: value_c = shifted;
            // compare results land in the least significant bit, index 31
            ALU_SEQ:                  value_c = word_t'(equal);
            ALU_SLT:                  value_c = word_t'(less);
            default:                  value_c = '0;
        endcase

        exe_c.value    = dec.illegal ? '0 : value_c;
        // overflow is only meaningful for the plain add and sub
        exe_c.overflow = !dec.illegal && (dec.op inside {ALU_ADD, ALU_SUB}) && add_ovf;
        exe_c.rd       = dec.rd;
        exe_c.illegal  = dec.illegal;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            exe <= exe_c;
        end
    end

endmodule

//--- src/result_stage.sv
`timescale 1ns/100ps

module result_stage import alu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  exe_t     exe,
    input  logic     exe_valid,
    output alu_rsp_t rsp,
    output logic     out_valid
);

    alu_rsp_t rsp_c;

    always_comb begin
        rsp_c.value    = exe.value;
        rsp_c.rd       = exe.rd;
        // flags describe the value as a signed word
        rsp_c.zero     = (exe.value == '0);
        rsp_c.negative = exe.value[0];
        rsp_c.overflow = exe.overflow;
        rsp_c.illegal  = exe.illegal;
        // r0 is hardwired, so writing it is dropped here
        rsp_c.wb_en    = !exe.illegal && (exe.rd != '0);
    end

    // the response holds its last value between strobes
    // and reads all zero straight out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp       <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= exe_valid;
            if (exe_valid) begin
                rsp <= rsp_c;
            end
        end
    end

endmodule

//--- src/alu_top.sv
`timescale 1ns/100ps

module alu_top import alu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  alu_req_t req,
    input  logic     in_valid,
    output alu_rsp_t rsp,
    output logic     out_valid
);

    // decode to execute
    dec_t dec;
    logic dec_valid;
    // execute to result
    exe_t exe;
    logic exe_valid;

    op_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .in_valid  (in_valid),
        .dec       (dec),
        .dec_valid (dec_valid)
    );

    alu_execute u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec       (dec),
        .dec_valid (dec_valid),
        .exe       (exe),
        .exe_valid (exe_valid)
    );

    // last register stage, its outputs are the unit's outputs
    result_stage u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .exe       (exe),
        .exe_valid (exe_valid),
        .rsp       (rsp),
        .out_valid (out_valid)
    );

endmodule

//--- test/alu_chk.sv
`timescale 1ns/100ps
`include "alu_consts.svh"

module alu_chk import alu_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     in_valid,
    input logic     out_valid,
    input alu_rsp_t rsp
);

    // each sampled strobe comes out a fixed number of edges later
    // and a response never appears without one
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, `ALU_LATENCY))
        else $error("out_valid does not follow in_valid by the pipeline latency");

    // nothing leaves the unit while it is held in reset
    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else $error("out_valid is high during reset");

    // r0 is never written
    a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
        rsp.wb_en |-> (rsp.rd != '0))
        else $error("write-back enabled for register 0");

    // an illegal instruction must not reach the register file
    a_illegal_no_wb: assert property (@(posedge clk) disable iff (!rst_n)
        rsp.illegal |-> !rsp.wb_en)
        else $error("write-back enabled for an illegal instruction");

endmodule

bind alu_top alu_chk u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .rsp       (rsp)
);

//--- test/alu_tb.sv
`timescale 1ns/100ps
`include "alu_consts.svh"

module alu_tb import alu_pkg::*; ();

    localparam int RST_CYCLES = 10;
    // shifts 384, add and sub 128, logic 72, compares 48, illegal and r0 10
    localparam int N_STROBES  = 642;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    alu_req_t req;
    alu_rsp_t rsp;
    logic     out_valid;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] rng_state = 32'h4382;
    // boundary words, their upper halves double as immediate corners
    logic [31:0] corner [0:3] = '{32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff, 32'h0000_0001};

    // expected responses in request order, with the name of the test that made each
    alu_rsp_t exp_q [$];
    string    name_q [$];
    alu_rsp_t exp_rsp;
    string    tname;

    alu_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .in_valid  (in_valid),
        .rsp       (rsp),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // destination register from the top bits, so r0 turns up now and then
    function automatic logic [4:0] pick_rd();
        logic [31:0] r;
        r = next_rand();
        return r[31:27];
    endfunction

    function automatic logic [31:0] encode_r(input logic [5:0] fn, input logic [4:0] rd);
        return {6'h00, 10'h000, rd, 5'h00, fn};
    endfunction

    function automatic logic [31:0] encode_i(input logic [5:0] opc, input logic [4:0] rd,
                                             input logic [15:0] imm);
        return {opc, 5'h00, rd, imm};
    endfunction

    // reference model in ordinary bit order, bit 31 is the sign here
    function automatic alu_rsp_t predict(input logic [31:0] instr, input logic [31:0] a,
                                         input logic [31:0] b);
        logic [5:0]  opc;
        logic [5:0]  fsel;
        logic [15:0] imm;
        logic [31:0] opb;
        logic [31:0] v;
        logic [4:0]  rd;
        logic        ill;
        logic        ovf;
        alu_rsp_t    rsp_e;
        opc = instr[31:26];
        imm = instr[15:0];
        // an I-type form behaves like its R-type function with the immediate as b
        case (opc)
            `OPC_RTYPE: fsel = instr[5:0];
            `OPC_ADDI:  fsel = `FUNC_ADD;
            `OPC_SUBI:  fsel = `FUNC_SUB;
            `OPC_ANDI:  fsel = `FUNC_AND;
            `OPC_ORI:   fsel = `FUNC_OR;
            `OPC_XORI:  fsel = `FUNC_XOR;
            `OPC_SLLI:  fsel = `FUNC_SLL;
            `OPC_SRLI:  fsel = `FUNC_SRL;
            `OPC_SRAI:  fsel = `FUNC_SRA;
            `OPC_SEQI:  fsel = `FUNC_SEQ;
            `OPC_SLTI:  fsel = `FUNC_SLT;
            default:    fsel = 6'h3F;
        endcase
        rd = (opc == `OPC_RTYPE) ? instr[15:11] : instr[20:16];
        if (opc == `OPC_RTYPE) begin
            opb = b;
        end else if (opc inside {`OPC_ADDI, `OPC_SUBI, `OPC_SEQI, `OPC_SLTI}) begin
            opb = {{16{imm[15]}}, imm};
        end else begin
            opb = {16'h0000, imm};
        end
        ill = 1'b0;
        ovf = 1'b0;
        v   = '0;
        // the shift amount is the low five bits of b or of the immediate
        case (fsel)
            `FUNC_ADD: begin
                v   = a + opb;
                ovf = (a[31] == opb[31]) && (v[31] != a[31]);
            end
            `FUNC_SUB: begin
                v   = a - opb;
                ovf = (a[31] != opb[31]) && (v[31] != a[31]);
            end
            `FUNC_AND: v = a & opb;
            `FUNC_OR:  v = a | opb;
            `FUNC_XOR: v = a ^ opb;
            `FUNC_SLL: v = a << opb[4:0];
            `FUNC_SRL: v = a >> opb[4:0];
            `FUNC_SRA: v = $signed(a) >>> opb[4:0];
            `FUNC_SEQ: v = {31'h0, a == opb};
            `FUNC_SLT: v = {31'h0, $signed(a) < $signed(opb)};
            default:   ill = 1'b1;
        endcase
        rsp_e.value    = v;
        rsp_e.rd       = rd;
        rsp_e.wb_en    = !ill && (rd != 5'd0);
        rsp_e.zero     = (v == 32'h0);
        rsp_e.negative = v[31];
        rsp_e.overflow = ovf;
        rsp_e.illegal  = ill;
        return rsp_e;
    endfunction

    task automatic check_field(input string test, input string field,
                               input logic [31:0] expv, input logic [31:0] actv);
        checks++;
        assert (actv == expv) else begin
            $display("Error: %s %s expected %h actual %h", test, field, expv, actv);
            errors++;
        end
    endtask

    // called on a falling edge, leaves in_valid low on the next falling edge
    task automatic issue(input string name, input logic [31:0] instr,
                         input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        r = next_rand();
        // idle gap of 0 to 3 cycles, a gap of 0 gives back-to-back strobes
        repeat (r[31:30]) @(negedge clk);
        req.instr = instr;
        req.a     = a;
        req.b     = b;
        in_valid  = 1'b1;
        exp_q.push_back(predict(instr, a, b));
        name_q.push_back(name);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // outputs settle after the rising edge, so they are read on the falling one
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("a response came out with no request outstanding");
                errors++;
            end else begin
                exp_rsp = exp_q.pop_front();
                tname   = name_q.pop_front();
                check_field(tname, "value", exp_rsp.value, rsp.value);
                check_field(tname, "rd", 32'(exp_rsp.rd), 32'(rsp.rd));
                check_field(tname, "wb_en", 32'(exp_rsp.wb_en), 32'(rsp.wb_en));
                check_field(tname, "zero", 32'(exp_rsp.zero), 32'(rsp.zero));
                check_field(tname, "negative", 32'(exp_rsp.negative), 32'(rsp.negative));
                check_field(tname, "overflow", 32'(exp_rsp.overflow), 32'(rsp.overflow));
                check_field(tname, "illegal", 32'(exp_rsp.illegal), 32'(rsp.illegal));
            end
        end
    end

    // each strobe takes at most 4 cycles including its gap
    initial begin
        repeat (N_STROBES * 4 + RST_CYCLES + 50) @(posedge clk);
        $display("timeout, the responses did not all arrive in time");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ai;
        logic [31:0] r;
        logic [15:0] imm;
        logic [4:0]  amt;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        req      = '0;
        // every output field reads 0 while reset is held
        repeat (RST_CYCLES) begin
            @(negedge clk);
            checks++;
            assert (rsp == '0 && out_valid == 1'b0) else begin
                $display("Error: reset expected rsp 0 out_valid 0 actual rsp %h out_valid %b",
                         rsp, out_valid);
                errors++;
            end
        end
        rst_n = 1'b1;

        // all 32 amounts on a positive and a negative word, junk above the amount bits
        for (int s = 0; s < 64; s++) begin
            amt = s[4:0];
            r   = next_rand();
            a   = s[5] ? (r | 32'h8000_0000) : (r & 32'h7fff_ffff);
            r   = next_rand();
            b   = {r[31:5], amt};
            imm = {r[15:5], amt};
            issue("sll", encode_r(`FUNC_SLL, pick_rd()), a, b);
            issue("srl", encode_r(`FUNC_SRL, pick_rd()), a, b);
            issue("sra", encode_r(`FUNC_SRA, pick_rd()), a, b);
            issue("slli", encode_i(`OPC_SLLI, pick_rd(), imm), a, b);
            issue("srli", encode_i(`OPC_SRLI, pick_rd(), imm), a, b);
            issue("srai", encode_i(`OPC_SRAI, pick_rd(), imm), a, b);
        end

        // every pairing of the boundary words, then random operands
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                issue("add", encode_r(`FUNC_ADD, pick_rd()), corner[i], corner[j]);
                issue("sub", encode_r(`FUNC_SUB, pick_rd()), corner[i], corner[j]);
                issue("addi", encode_i(`OPC_ADDI, pick_rd(), corner[j][31:16]), corner[i], 0);
                issue("subi", encode_i(`OPC_SUBI, pick_rd(), corner[j][31:16]), corner[i], 0);
            end
        end
        for (int i = 0; i < 16; i++) begin
            a = next_rand();
            b = next_rand();
            issue("add", encode_r(`FUNC_ADD, pick_rd()), a, b);
            issue("sub", encode_r(`FUNC_SUB, pick_rd()), a, b);
            issue("addi", encode_i(`OPC_ADDI, pick_rd(), b[15:0]), a, b);
            issue("subi", encode_i(`OPC_SUBI, pick_rd(), b[31:16]), a, b);
        end

        // every other immediate has bit 15 set, which must not spread upward
        for (int i = 0; i < 12; i++) begin
            a   = next_rand();
            b   = next_rand();
            r   = next_rand();
            imm = r[15:0] | (i[0] ? 16'h8000 : 16'h0000);
            issue("and", encode_r(`FUNC_AND, pick_rd()), a, b);
            issue("or", encode_r(`FUNC_OR, pick_rd()), a, b);
            issue("xor", encode_r(`FUNC_XOR, pick_rd()), a, b);
            issue("andi", encode_i(`OPC_ANDI, pick_rd(), imm), a, b);
            issue("ori", encode_i(`OPC_ORI, pick_rd(), imm), a, b);
            issue("xori", encode_i(`OPC_XORI, pick_rd(), imm), a, b);
        end

        // compares cycle through equal, negative against positive, the reverse, random
        for (int i = 0; i < 12; i++) begin
            a   = next_rand();
            b   = next_rand();
            r   = next_rand();
            imm = r[15:0];
            case (i % 4)
                0: begin
                    b  = a;
                    ai = {{16{imm[15]}}, imm};
                end
                1: begin
                    a   = a | 32'h8000_0000;
                    b   = b & 32'h7fff_ffff;
                    imm = imm & 16'h7fff;
                    ai  = a;
                end
                2: begin
                    a   = a & 32'h7fff_ffff;
                    b   = b | 32'h8000_0000;
                    imm = imm | 16'h8000;
                    ai  = a;
                end
                default: ai = a;
            endcase
            issue("seq", encode_r(`FUNC_SEQ, pick_rd()), a, b);
            issue("slt", encode_r(`FUNC_SLT, pick_rd()), a, b);
            issue("seqi", encode_i(`OPC_SEQI, pick_rd(), imm), ai, b);
            issue("slti", encode_i(`OPC_SLTI, pick_rd(), imm), ai, b);
        end

        // unknown opcodes and functions with a live rd, then legal work aimed at r0
        a = next_rand();
        b = next_rand();
        issue("illegal_opc01", encode_i(6'h01, 5'd7, b[15:0]), a, b);
        issue("illegal_opc3f", encode_i(6'h3F, 5'd7, b[15:0]), a, b);
        issue("illegal_opc09", encode_i(6'h09, 5'd7, b[15:0]), a, b);
        issue("illegal_opc15", encode_i(6'h15, 5'd7, b[15:0]), a, b);
        issue("illegal_fn00", encode_r(6'h00, 5'd7), a, b);
        issue("illegal_fn21", encode_r(6'h21, 5'd7), a, b);
        issue("add_r0", encode_r(`FUNC_ADD, 5'd0), a, b);
        issue("addi_r0", encode_i(`OPC_ADDI, 5'd0, b[15:0]), a, b);
        issue("sll_r0", encode_r(`FUNC_SLL, 5'd0), a, b);
        issue("slti_r0", encode_i(`OPC_SLTI, 5'd0, b[15:0]), a, b);

        // the watchdog catches a response that never comes
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+src
src/alu_pkg.sv
src/barrel_shift.sv
src/op_decode.sv
src/alu_execute.sv
src/result_stage.sv
src/alu_top.sv
test/alu_chk.sv
test/alu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and pass only when the pass line shows up

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module alu_tb -f tb.f \
    --Mdir obj_dir -o alu_sim \
    && ./obj_dir/alu_sim | tee /dev/stderr | grep -qxF '>>> PASS' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
